// ==== src/ext_mem_macros.svh ====
`ifndef EXT_MEM_MACROS_SVH
`define EXT_MEM_MACROS_SVH

// Word address and data widths
`define ADDR_W      16
`define DATA_W      32
`define STRB_W      (`DATA_W / 8)

// Direct-mapped cache geometry, one word per line
`define IDX_W       4
`define LINES       (1 << `IDX_W)
`define TAG_W       (`ADDR_W - `IDX_W)

// Hit and miss counter width
`define CNT_W       16

// Buffers the external memory grants after reset
`define EXT_CREDITS 4

`endif

// ==== src/mem_bus_pkg.sv ====
`default_nettype none
`include "ext_mem_macros.svh"

package mem_bus_pkg;

   // Native request, held by the master until ready
   // A zero strobe marks a read
   typedef struct packed {
      logic               valid;
      logic [`ADDR_W-1:0] addr;
      logic [`DATA_W-1:0] wdata;
      logic [`STRB_W-1:0] wstrb;
   } mem_req_t;

   // Native response, ready is a single-cycle pulse
   typedef struct packed {
      logic               ready;
      logic [`DATA_W-1:0] rdata;
   } mem_resp_t;

   // Request word on the credit link
   typedef struct packed {
      logic [`ADDR_W-1:0] addr;
      logic [`DATA_W-1:0] wdata;
      logic [`STRB_W-1:0] wstrb;
   } ext_req_t;

   // One response per request, in order, writes included
   typedef struct packed {
      logic [`DATA_W-1:0] rdata;
   } ext_rsp_t;

endpackage

`default_nettype wire

// ==== src/cache_pkg.sv ====
`default_nettype none
`include "ext_mem_macros.svh"

package cache_pkg;

   typedef logic [`TAG_W-1:0] tag_t;
   typedef logic [`IDX_W-1:0] idx_t;

   // Word address seen as tag over index
   typedef struct packed {
      tag_t tag;
      idx_t idx;
   } addr_split_t;

   // One direct-mapped entry
   typedef struct packed {
      logic               valid;
      tag_t               tag;
      logic [`DATA_W-1:0] data;
   } line_t;

endpackage

`default_nettype wire

// ==== src/l1_cache.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ext_mem_macros.svh"

module l1_cache (
   input  wire                          clk,
   input  wire                          rst_n,

   // Front end, toward the processor
   input  wire mem_bus_pkg::mem_req_t   fe_req,
   output mem_bus_pkg::mem_resp_t       fe_resp,

   // Back end, toward the merge
   output mem_bus_pkg::mem_req_t        be_req,
   input  wire mem_bus_pkg::mem_resp_t  be_resp,

   output logic [`CNT_W-1:0]            hits,
   output logic [`CNT_W-1:0]            misses
);
   import mem_bus_pkg::*;
   import cache_pkg::*;

   typedef enum logic [1:0] {
      S_IDLE,
      S_LOOKUP,
      S_BE_WAIT,
      S_RESPOND
   } state_t;

   state_t             state;
   mem_req_t           req_q;
   line_t              lines [`LINES];
   addr_split_t        addr_s;
   idx_t               idx;
   line_t              cur_line;
   logic               is_read;
   logic               hit;
   logic [`DATA_W-1:0] fill_q;
   logic [`DATA_W-1:0] merged;

   assign addr_s   = addr_split_t'(req_q.addr);
   assign idx      = addr_s.idx;
   assign cur_line = lines[idx];
   assign is_read  = (req_q.wstrb == '0);
   assign hit      = cur_line.valid && (cur_line.tag == addr_s.tag);

   // Stored word with the strobed bytes replaced
   always_comb begin
      merged = cur_line.data;
      for (int b = 0; b < `STRB_W; b++) begin
         if (req_q.wstrb[b]) begin
            merged[8*b +: 8] = req_q.wdata[8*b +: 8];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state  <= S_IDLE;
         hits   <= '0;
         misses <= '0;
      end else begin
         case (state)
            S_IDLE: begin
               if (fe_req.valid) begin
                  state <= S_LOOKUP;
               end
            end
            S_LOOKUP: begin
               // Only reads are counted
               if (is_read && hit) begin
                  hits  <= hits + 1'b1;
                  state <= S_IDLE;
               end else begin
                  if (is_read) begin
                     misses <= misses + 1'b1;
                  end
                  state <= S_BE_WAIT;
               end
            end
            S_BE_WAIT: begin
               if (be_resp.ready) begin
                  state <= S_RESPOND;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // Request and fill word
   always_ff @(posedge clk) begin
      if (state == S_IDLE && fe_req.valid) begin
         req_q <= fe_req;
      end
      if (state == S_BE_WAIT && be_resp.ready) begin
         fill_q <= be_resp.rdata;
      end
   end

   // Write hits patch the line; write misses leave the array alone
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < `LINES; i++) begin
            lines[i].valid <= 1'b0;
         end
      end else if (state == S_LOOKUP && !is_read && hit) begin
         lines[idx].data <= merged;
      end else if (state == S_BE_WAIT && be_resp.ready && is_read) begin
         lines[idx] <= '{valid: 1'b1, tag: addr_s.tag, data: be_resp.rdata};
      end
   end

   always_comb begin
      fe_resp.ready = (state == S_RESPOND) || (state == S_LOOKUP && is_read && hit);
      fe_resp.rdata = (state == S_RESPOND) ? fill_q : cur_line.data;
      // Write-through also carries the front-end strobes
      be_req.valid  = (state == S_BE_WAIT);
      be_req.addr   = req_q.addr;
      be_req.wdata  = req_q.wdata;
      be_req.wstrb  = req_q.wstrb;
   end

endmodule

`default_nettype wire

// ==== src/bus_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_merge #(
   parameter type req_t = mem_bus_pkg::mem_req_t
) (
   input  wire                          clk,
   input  wire                          rst_n,

   // Masters, index 0 and 1
   input  wire req_t                    m_req  [2],
   output mem_bus_pkg::mem_resp_t       m_resp [2],

   // Single slave
   output req_t                         s_req,
   input  wire mem_bus_pkg::mem_resp_t  s_resp
);

   logic busy;
   logic owner;
   logic last;
   logic pick;
   logic any_req;

   assign any_req = m_req[0].valid | m_req[1].valid;

   // On a tie the master not served last wins
   assign pick = (m_req[0].valid && m_req[1].valid) ? ~last : m_req[1].valid;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy  <= 1'b0;
         owner <= 1'b0;
         last  <= 1'b1;
      end else if (!busy) begin
         if (any_req) begin
            busy  <= 1'b1;
            owner <= pick;
         end
      end else if (s_resp.ready) begin
         // Owner released once the slave answers
         busy <= 1'b0;
         last <= owner;
      end
   end

   // Owner payload passes through, valid only while granted
   always_comb begin
      s_req = m_req[owner];
      if (!busy) begin
         s_req.valid = 1'b0;
      end
   end

   always_comb begin
      for (int i = 0; i < 2; i++) begin
         m_resp[i].ready = busy && (owner == 1'(i)) && s_resp.ready;
         m_resp[i].rdata = (owner == 1'(i)) ? s_resp.rdata : '0;
      end
   end

endmodule

`default_nettype wire

// ==== src/ext_link.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ext_mem_macros.svh"

module ext_link (
   input  wire                          clk,
   input  wire                          rst_n,

   // Merged native bus
   input  wire mem_bus_pkg::mem_req_t   req,
   output mem_bus_pkg::mem_resp_t       resp,

   // Credit-based external link
   output logic                         ext_req_valid,
   output mem_bus_pkg::ext_req_t        ext_req,
   input  wire                          ext_credit,
   input  wire                          ext_rsp_valid,
   input  wire mem_bus_pkg::ext_rsp_t   ext_rsp
);

   localparam int CRED_W = $clog2(`EXT_CREDITS + 1);

   typedef enum logic [1:0] {
      L_IDLE,
      L_ISSUE,
      L_WAIT,
      L_RESP
   } state_t;

   state_t             state;
   logic [CRED_W-1:0]  credits;
   logic [`DATA_W-1:0] rdata_q;

   // Stalls in issue while the memory has no free buffer
   assign ext_req_valid = (state == L_ISSUE) && (credits != '0);

   // Master holds the request until ready, so no copy is kept
   assign ext_req.addr  = req.addr;
   assign ext_req.wdata = req.wdata;
   assign ext_req.wstrb = req.wstrb;

   assign resp.ready = (state == L_RESP);
   assign resp.rdata = rdata_q;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         credits <= CRED_W'(`EXT_CREDITS);
      end else begin
         credits <= credits - CRED_W'(ext_req_valid) + CRED_W'(ext_credit);
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= L_IDLE;
      end else begin
         case (state)
            L_IDLE:  if (req.valid) state <= L_ISSUE;
            L_ISSUE: if (ext_req_valid) state <= L_WAIT;
            L_WAIT:  if (ext_rsp_valid) state <= L_RESP;
            default: state <= L_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == L_WAIT && ext_rsp_valid) begin
         rdata_q <= ext_rsp.rdata;
      end
   end

endmodule

`default_nettype wire

// ==== src/ext_mem.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ext_mem_macros.svh"

module ext_mem (
   input  wire                          clk,
   input  wire                          rst_n,

   // Instruction and data buses
   input  wire mem_bus_pkg::mem_req_t   i_req,
   output mem_bus_pkg::mem_resp_t       i_resp,
   input  wire mem_bus_pkg::mem_req_t   d_req,
   output mem_bus_pkg::mem_resp_t       d_resp,

   output logic [`CNT_W-1:0]            d_hits,
   output logic [`CNT_W-1:0]            d_misses,
   output logic [`CNT_W-1:0]            i_hits,
   output logic [`CNT_W-1:0]            i_misses,

   // External memory link
   output logic                         ext_req_valid,
   output mem_bus_pkg::ext_req_t        ext_req,
   input  wire                          ext_credit,
   input  wire                          ext_rsp_valid,
   input  wire mem_bus_pkg::ext_rsp_t   ext_rsp
);
   import mem_bus_pkg::*;

   // Back ends, icache on master 0 and dcache on master 1
   mem_req_t  be_req  [2];
   mem_resp_t be_resp [2];

   mem_req_t  link_req;
   mem_resp_t link_resp;

   l1_cache icache (
      .clk     (clk),
      .rst_n   (rst_n),
      .fe_req  (i_req),
      .fe_resp (i_resp),
      .be_req  (be_req[0]),
      .be_resp (be_resp[0]),
      .hits    (i_hits),
      .misses  (i_misses)
   );

   l1_cache dcache (
      .clk     (clk),
      .rst_n   (rst_n),
      .fe_req  (d_req),
      .fe_resp (d_resp),
      .be_req  (be_req[1]),
      .be_resp (be_resp[1]),
      .hits    (d_hits),
      .misses  (d_misses)
   );

   bus_merge #(
      .req_t (mem_req_t)
   ) merge_i_d (
      .clk    (clk),
      .rst_n  (rst_n),
      .m_req  (be_req),
      .m_resp (be_resp),
      .s_req  (link_req),
      .s_resp (link_resp)
   );

   ext_link link (
      .clk           (clk),
      .rst_n         (rst_n),
      .req           (link_req),
      .resp          (link_resp),
      .ext_req_valid (ext_req_valid),
      .ext_req       (ext_req),
      .ext_credit    (ext_credit),
      .ext_rsp_valid (ext_rsp_valid),
      .ext_rsp       (ext_rsp)
   );

endmodule

`default_nettype wire

// ==== tb/ext_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ext_mem_macros.svh"

module ext_mem_model #(
   parameter logic [`DATA_W-1:0] FILL = '0
) (
   input  wire                          clk,
   input  wire                          rst_n,
   input  wire                          ext_req_valid,
   input  wire mem_bus_pkg::ext_req_t   ext_req,
   output logic                         ext_credit,
   output logic                         ext_rsp_valid,
   output mem_bus_pkg::ext_rsp_t        ext_rsp,
   // Random draws and credit hold, from the testbench
   input  wire [2:0]                    lat_rand,
   input  wire [1:0]                    cdly_rand,
   input  wire                          hold_credits
);
   import mem_bus_pkg::*;

   typedef struct packed {
      ext_req_t    req;
      logic [31:0] due;
   } pend_t;

   // Word array, also read by the testbench as the shadow copy
   logic [`DATA_W-1:0] mem [1 << `ADDR_W];

   initial begin
      pend_t              pend [$];
      pend_t              head;
      logic [`DATA_W-1:0] word;
      logic [31:0]        cycle;
      int                 owed;
      int                 cdly;
      ext_credit    = 1'b0;
      ext_rsp_valid = 1'b0;
      ext_rsp       = '0;
      cycle         = '0;
      owed          = 0;
      cdly          = 0;
      for (int a = 0; a < (1 << `ADDR_W); a++) begin
         mem[a] = `DATA_W'(a) ^ FILL;
      end
      forever begin
         @(negedge clk);
         ext_credit    = 1'b0;
         ext_rsp_valid = 1'b0;
         if (!rst_n) begin
            pend.delete();
            cycle = '0;
            owed  = 0;
            cdly  = 0;
         end else begin
            cycle = cycle + 1;
            if (ext_req_valid) begin
               pend.push_back('{req: ext_req, due: cycle + 32'(lat_rand) + 32'd1});
            end
            // Oldest request answers first once its latency has run out
            if (pend.size() > 0 && pend[0].due <= cycle) begin
               head = pend.pop_front();
               word = mem[head.req.addr];
               for (int b = 0; b < `STRB_W; b++) begin
                  if (head.req.wstrb[b]) begin
                     word[8*b +: 8] = head.req.wdata[8*b +: 8];
                  end
               end
               mem[head.req.addr] = word;
               ext_rsp_valid      = 1'b1;
               ext_rsp.rdata      = word;
               owed++;
            end
            // Freed buffers go back one per pulse, after a random gap
            if (owed > 0 && !hold_credits) begin
               if (cdly == 0) begin
                  ext_credit = 1'b1;
                  owed--;
                  cdly = int'(cdly_rand);
               end else begin
                  cdly--;
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== tb/tb_ext_mem.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ext_mem_macros.svh"

module tb_ext_mem;
   import mem_bus_pkg::*;

   localparam int                 TIMEOUT = 200;
   localparam logic [`DATA_W-1:0] FILL    = 32'hC3A5_5A3C;

   logic               clk          = 1'b0;
   logic               rst_n;
   mem_req_t           i_req;
   mem_resp_t          i_resp;
   mem_req_t           d_req;
   mem_resp_t          d_resp;
   logic [`CNT_W-1:0]  d_hits;
   logic [`CNT_W-1:0]  d_misses;
   logic [`CNT_W-1:0]  i_hits;
   logic [`CNT_W-1:0]  i_misses;
   logic               ext_req_valid;
   ext_req_t           ext_req;
   logic               ext_credit;
   logic               ext_rsp_valid;
   ext_rsp_t           ext_rsp;

   logic [15:0]        lfsr         = 16'd97;
   logic [2:0]         lat_rand     = '0;
   logic [1:0]         cdly_rand    = '0;
   logic               hold_credits;
   int                 issued       = 0;
   int                 returned     = 0;
   int                 exp_ih       = 0;
   int                 exp_im       = 0;
   int                 exp_dh       = 0;
   int                 exp_dm       = 0;

   ext_mem ext_mem_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .i_req         (i_req),
      .i_resp        (i_resp),
      .d_req         (d_req),
      .d_resp        (d_resp),
      .d_hits        (d_hits),
      .d_misses      (d_misses),
      .i_hits        (i_hits),
      .i_misses      (i_misses),
      .ext_req_valid (ext_req_valid),
      .ext_req       (ext_req),
      .ext_credit    (ext_credit),
      .ext_rsp_valid (ext_rsp_valid),
      .ext_rsp       (ext_rsp)
   );

   ext_mem_model #(
      .FILL (FILL)
   ) mem_model (
      .clk           (clk),
      .rst_n         (rst_n),
      .ext_req_valid (ext_req_valid),
      .ext_req       (ext_req),
      .ext_credit    (ext_credit),
      .ext_rsp_valid (ext_rsp_valid),
      .ext_rsp       (ext_rsp),
      .lat_rand      (lat_rand),
      .cdly_rand     (cdly_rand),
      .hold_credits  (hold_credits)
   );

   always #5 clk = ~clk;

   // Fibonacci LFSR with feedback x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [7:0] rand_bits(input int n);
      logic [7:0] v;
      logic       fb;
      v = '0;
      for (int k = 0; k < n; k++) begin
         fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         v    = {v[6:0], fb};
      end
      return v;
   endfunction

   always @(posedge clk) begin
      lat_rand  <= 3'(rand_bits(3));
      cdly_rand <= 2'(rand_bits(2));
   end

   function automatic logic [`DATA_W-1:0] preload_word(input logic [`ADDR_W-1:0] a);
      return {16'h0, a} ^ FILL;
   endfunction

   function automatic logic [`DATA_W-1:0] apply_strobes(
      input logic [`DATA_W-1:0] old,
      input logic [`DATA_W-1:0] wdata,
      input logic [`STRB_W-1:0] wstrb
   );
      logic [`DATA_W-1:0] v;
      v = old;
      for (int b = 0; b < `STRB_W; b++) begin
         if (wstrb[b]) begin
            v[8*b +: 8] = wdata[8*b +: 8];
         end
      end
      return v;
   endfunction

   task automatic abort_run();
      $display("Done: errors found");
      $fatal(1);
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
         abort_run();
      end
   endtask

   // Credits the link may still use as seen from outside
   function automatic int credits_left();
      return `EXT_CREDITS + returned - issued;
   endfunction

   always @(posedge clk) begin
      if (!rst_n) begin
         returned <= 0;
      end else if (ext_credit) begin
         returned <= returned + 1;
      end
   end

   always @(negedge clk) begin
      if (!rst_n) begin
         issued <= 0;
      end else if (ext_req_valid) begin
         if (credits_left() <= 0) begin
            $display("External request issued with no credit left");
            abort_run();
         end
         issued <= issued + 1;
      end
   end

   task automatic access(
      input  logic               is_d,
      input  logic [`ADDR_W-1:0] addr,
      input  logic [`DATA_W-1:0] wdata,
      input  logic [`STRB_W-1:0] wstrb,
      output logic [`DATA_W-1:0] rdata
   );
      mem_req_t  req;
      mem_resp_t resp;
      int        n;
      req = '{valid: 1'b1, addr: addr, wdata: wdata, wstrb: wstrb};
      @(negedge clk);
      if (is_d) d_req = req;
      else i_req = req;
      resp = '0;
      n    = 0;
      while (!resp.ready) begin
         if (n == TIMEOUT) begin
            $display("Timeout waiting for %s ready", is_d ? "d_resp" : "i_resp");
            abort_run();
         end
         @(negedge clk);
         resp = is_d ? d_resp : i_resp;
         n++;
      end
      rdata     = resp.rdata;
      req.valid = 1'b0;
      if (is_d) d_req = req;
      else i_req = req;
      // Lets the counters settle before the caller looks
      @(negedge clk);
   endtask

   task automatic check_counters();
      check("i_hits", 32'(i_hits), 32'(exp_ih));
      check("i_misses", 32'(i_misses), 32'(exp_im));
      check("d_hits", 32'(d_hits), 32'(exp_dh));
      check("d_misses", 32'(d_misses), 32'(exp_dm));
   endtask

   task automatic idle_after_reset();
      check("i_resp.ready", 32'(i_resp.ready), 32'h0);
      check("d_resp.ready", 32'(d_resp.ready), 32'h0);
      check("ext_req_valid", 32'(ext_req_valid), 32'h0);
      check_counters();
   endtask

   task automatic read_miss_then_hit();
      logic [`DATA_W-1:0] rd;
      access(1'b1, 16'h0012, '0, '0, rd);
      exp_dm++;
      check("d_resp.rdata", rd, preload_word(16'h0012));
      check_counters();
      access(1'b1, 16'h0012, '0, '0, rd);
      exp_dh++;
      check("d_resp.rdata", rd, preload_word(16'h0012));
      check_counters();
   endtask

   task automatic partial_write();
      logic [`DATA_W-1:0] rd;
      logic [`DATA_W-1:0] exp;
      exp = apply_strobes(preload_word(16'h0012), 32'h1122_3344, 4'b0110);
      access(1'b1, 16'h0012, 32'h1122_3344, 4'b0110, rd);
      check_counters();
      check("mem_model.mem[0x0012]", mem_model.mem[16'h0012], exp);
      access(1'b1, 16'h0012, '0, '0, rd);
      exp_dh++;
      check("d_resp.rdata", rd, exp);
      check_counters();
   endtask

   task automatic index_conflict();
      logic [`DATA_W-1:0] rd;
      logic [`ADDR_W-1:0] a;
      for (int k = 0; k < 4; k++) begin
         a = k[0] ? 16'h0215 : 16'h0105;
         access(1'b1, a, '0, '0, rd);
         exp_dm++;
         check("d_resp.rdata", rd, preload_word(a));
         check_counters();
      end
   endtask

   task automatic parallel_fetch();
      logic [`DATA_W-1:0] rd_i;
      logic [`DATA_W-1:0] rd_d;
      fork
         access(1'b0, 16'h0040, '0, '0, rd_i);
         access(1'b1, 16'h0077, '0, '0, rd_d);
      join
      exp_im++;
      exp_dm++;
      check("i_resp.rdata", rd_i, preload_word(16'h0040));
      check("d_resp.rdata", rd_d, preload_word(16'h0077));
      check_counters();
      // Same instruction again now hits in the icache
      access(1'b0, 16'h0040, '0, '0, rd_i);
      exp_ih++;
      check("i_resp.rdata", rd_i, preload_word(16'h0040));
      check_counters();
   endtask

   task automatic credit_stall();
      logic [`DATA_W-1:0] rd;
      int                 n;
      @(posedge clk);
      hold_credits <= 1'b1;
      fork
         begin
            for (int k = 0; k < 6; k++) begin
               access(1'b1, 16'h0300 + 16'(k), '0, '0, rd);
               exp_dm++;
               check("d_resp.rdata", rd, preload_word(16'h0300 + 16'(k)));
            end
         end
         begin
            n = 0;
            while (credits_left() != 0) begin
               if (n == TIMEOUT) begin
                  $display("Link credits never ran out while returns were held");
                  abort_run();
               end
               @(negedge clk);
               n++;
            end
            repeat (20) @(negedge clk);
            @(posedge clk);
            hold_credits <= 1'b0;
         end
      join
      check_counters();
   endtask

   initial begin
      rst_n        = 1'b0;
      i_req        = '0;
      d_req        = '0;
      hold_credits = 1'b0;
      repeat (10) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      idle_after_reset();
      read_miss_then_hit();
      partial_write();
      index_conflict();
      parallel_fetch();
      credit_stall();
      $display("Done: no errors");
      $finish;
   end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+src
src/mem_bus_pkg.sv
src/cache_pkg.sv
src/l1_cache.sv
src/bus_merge.sv
src/ext_link.sv
src/ext_mem.sv
tb/ext_mem_model.sv
tb/tb_ext_mem.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
TOP       ?= tb_ext_mem
FILELIST  ?= compile.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
